// File: src/ft64_macros.svh
/*
 * Instruction and parcel widths, fixed register numbers,
 * control register block addresses
 */
`ifndef FT64_MACROS_SVH
`define FT64_MACROS_SVH

// ====================
// Widths
// ====================
`define INSTR_WIDTH 48
`define PARCEL_WIDTH 16
`define REG_DATA_WIDTH 32

// ====================
// Fixed registers
// ====================
`define REG_SP 5'd31 // Stack pointer
`define REG_FP 5'd30 // Frame pointer
`define REG_LR 5'd29 // Return address

// ====================
// Register block map
// ====================
`define REG_ADDR_CTRL 2'd0 // Bit 0 enables compressed decode
`define REG_ADDR_EXPANDED 2'd1
`define REG_ADDR_ILLEGAL 2'd2
`define REG_ADDR_TOTAL 2'd3

`endif

// File: src/ft64Pkg.sv
/*
 * Major opcode and aligner state enums, aligned instruction and
 * event structs, the NOP instruction constant
 */
`include "ft64_macros.svh"
`default_nettype none

package ft64Pkg;

	// Major opcode in bits 5:0 of every instruction
	typedef enum logic [5:0]
	{
		R2 = 6'h02,
		BRK,
		ADDI,
		ORI,
		ANDI,
		RET,
		JAL,
		Bcc = 6'h38,
		Lx,
		Sx,
		MEMNDX,
		NOP
	} opcodeE;

	// Named after the parcel the aligner waits for
	typedef enum logic [1:0]
	{
		IDLE,
		NEED2,
		NEED3
	} alignStateE;

	typedef struct packed
	{
		logic [`INSTR_WIDTH-1:0] bits; // Zero-extended, first parcel lowest
		logic isCompressed;
	} alignedInstrT;

	// One-cycle pulses toward the counters
	typedef struct packed
	{
		logic expanded;
		logic illegal;
		logic issued;
	} expandEventsT;

	// NOP with all fields zero
	localparam logic [`INSTR_WIDTH-1:0] nopInstr = {{(`INSTR_WIDTH-8){1'b0}}, 2'b10, NOP};

endpackage

`default_nettype wire

// File: src/compressedExpander.sv
/*
 * Combinational expander from one compressed parcel
 * to the full 48-bit instruction form
 */
`timescale 1ns/1ps
`include "ft64_macros.svh"
`default_nettype none

module compressedExpander (
	input logic [`PARCEL_WIDTH-1:0] cinstr,
	output logic [`INSTR_WIDTH-1:0] expand
);
	import ft64Pkg::*;

	// R2 function codes, bits 31:26
	localparam logic [5:0] functAdd = 6'h04;
	localparam logic [5:0] functSub = 6'h05;
	localparam logic [5:0] functAnd = 6'h08;
	localparam logic [5:0] functOr = 6'h09;
	localparam logic [5:0] functXor = 6'h0A;
	localparam logic [5:0] functMov = 6'h12;
	localparam logic [5:0] shiftImm = 6'h0F; // Shift by immediate 0-31
	localparam logic [2:0] wordSize = 3'b011;
	localparam logic [2:0] condBeq = 3'd0;
	localparam logic [2:0] condBne = 3'd1;

	logic [4:0] rd; // Full register field
	logic [4:0] imm5; // Split immediate {11:8, 5}
	logic [4:0] shiftAmt;
	logic immSign;
	logic [4:0] rpA; // Mapped from 2:0
	logic [4:0] rpB; // Mapped from {9:8, 3}
	logic [4:0] rpC; // Mapped from {9:8, 5}

	// Eight most used registers reachable from a 3-bit field
	function automatic logic [4:0] regMap(input logic [2:0] rg);
		case (rg)
			3'd0: return 5'd1; // Return value
			3'd1: return 5'd3;
			3'd2: return 5'd4;
			3'd3: return 5'd11; // Register variables
			3'd4: return 5'd12;
			3'd5: return 5'd18; // Arguments
			3'd6: return 5'd19;
			default: return 5'd20;
		endcase
	endfunction

	// Fields at 31:23, 22:18, 17:13 and 12:8
	function automatic logic [`INSTR_WIDTH-1:0] encode(
		input opcodeE op,
		input logic [8:0] hi,
		input logic [4:0] rb,
		input logic [4:0] rt,
		input logic [4:0] ra
	);
		return {16'h0000, hi, rb, rt, ra, 2'b10, op};
	endfunction

	// 14-bit immediate in 31:18
	function automatic logic [`INSTR_WIDTH-1:0] immForm(
		input opcodeE op,
		input logic [13:0] imm,
		input logic [4:0] rt,
		input logic [4:0] ra
	);
		return encode(op, imm[13:5], imm[4:0], rt, ra);
	endfunction

	assign rd = cinstr[4:0];
	assign imm5 = {cinstr[11:8], cinstr[5]};
	assign shiftAmt = {cinstr[11:8], cinstr[3]};
	assign immSign = cinstr[11];
	assign rpA = regMap(cinstr[2:0]);
	assign rpB = regMap({cinstr[9:8], cinstr[3]});
	assign rpC = regMap({cinstr[9:8], cinstr[5]});

	always_comb
	begin
		expand = nopInstr; // Unlisted patterns
		casez ({cinstr[15:12], cinstr[6]})
			// ====================
			// Immediate forms
			// ====================
			5'b00000:
				if (rd == `REG_SP)
					expand = immForm(ADDI, {{6{immSign}}, imm5, 3'b000}, rd, rd); // Scaled by 8
				else
					expand = immForm(ADDI, {{9{immSign}}, imm5}, rd, rd);
			5'b00010:
				if (rd == 5'd0)
					expand = immForm(BRK, {8'd0, 3'd1, 3'd0}, 5'd1, imm5); // Cause in Ra
				else
					expand = immForm(ORI, {{9{immSign}}, imm5}, rd, 5'd0); // LDI
			5'b00100:
				if (rd == 5'd0)
					expand = encode(RET, {4'd0, imm5}, `REG_LR, `REG_SP, `REG_SP);
				else
					expand = immForm(ANDI, {{9{immSign}}, imm5}, rd, rd);
			5'b00110: expand = encode(R2, {shiftImm, 3'd0}, imm5, rd, rd); // SHLI
			5'b01000:
				case (cinstr[5:4])
					2'd0: expand = encode(R2, {shiftImm, 3'd1}, shiftAmt, rpA, rpA); // SHRI
					2'd1: expand = encode(R2, {shiftImm, 3'd3}, shiftAmt, rpA, rpA); // ASRI
					2'd2: expand = immForm(ORI, {{9{immSign}}, shiftAmt}, rpA, rpA);
					default:
						case (cinstr[11:10])
							2'd0: expand = encode(R2, {functSub, wordSize}, rpB, rpA, rpA);
							2'd1: expand = encode(R2, {functAnd, wordSize}, rpB, rpA, rpA);
							2'd2: expand = encode(R2, {functOr, wordSize}, rpB, rpA, rpA);
							default: expand = encode(R2, {functXor, wordSize}, rpB, rpA, rpA);
						endcase
				endcase

			// ====================
			// Flow control
			// ====================
			5'b01110: // Always taken, r0 == r0
				expand = encode(Bcc, {immSign, cinstr[11:8], cinstr[5:2]}, 5'd0,
					{cinstr[1:0], condBeq}, 5'd0);
			5'b10??0:
				expand = encode(Bcc, {{4{cinstr[13]}}, cinstr[13:9]}, 5'd0,
					{cinstr[8], cinstr[5], condBeq}, rd);
			5'b11??0:
				expand = encode(Bcc, {{4{cinstr[13]}}, cinstr[13:9]}, 5'd0,
					{cinstr[8], cinstr[5], condBne}, rd);
			5'b00001: expand = encode(R2, {functMov, 3'd7}, 5'd0, imm5, rd);
			5'b00011: expand = encode(R2, {functAdd, wordSize}, imm5, rd, rd);
			5'b00101: expand = immForm(JAL, 14'd0, imm5, rd); // JALR
			5'b00111:
				if (imm5 == 5'd0)
					expand = encode(MEMNDX, {4'hC, 5'd0}, rd, `REG_SP, `REG_SP); // PUSH

			// ====================
			// Loads and stores
			// ====================
			5'b01001: expand = immForm(Lx, {{7{immSign}}, imm5, 2'd2}, rd, `REG_SP); // LH
			5'b01011: expand = immForm(Lx, {{6{immSign}}, imm5, 3'd4}, rd, `REG_SP); // LW
			5'b01101: expand = immForm(Lx, {{7{immSign}}, imm5, 2'd2}, rd, `REG_FP);
			5'b01111: expand = immForm(Lx, {{6{immSign}}, imm5, 3'd4}, rd, `REG_FP);
			5'b10001:
				expand = encode(Sx, {{7{immSign}}, cinstr[11:10]}, rd,
					{cinstr[9:8], cinstr[5], 2'd2}, `REG_SP); // SH
			5'b10011:
				expand = encode(Sx, {{6{immSign}}, cinstr[11:9]}, rd,
					{cinstr[8], cinstr[5], 3'd4}, `REG_SP); // SW
			5'b10101:
				expand = encode(Sx, {{7{immSign}}, cinstr[11:10]}, rd,
					{cinstr[9:8], cinstr[5], 2'd2}, `REG_FP);
			5'b10111:
				expand = encode(Sx, {{6{immSign}}, cinstr[11:9]}, rd,
					{cinstr[8], cinstr[5], 3'd4}, `REG_FP);
			5'b11001:
				expand = immForm(Lx, {{8{immSign}}, cinstr[11:10], cinstr[4:3], 2'd2}, rpC, rpA);
			5'b11011:
				expand = immForm(Lx, {{7{immSign}}, cinstr[11:10], cinstr[4:3], 3'd4}, rpC, rpA);
			5'b11101:
				expand = encode(Sx, {{8{immSign}}, immSign}, rpC,
					{cinstr[10], cinstr[4:3], 2'd2}, rpA);
			5'b11111:
				expand = encode(Sx, {{7{immSign}}, cinstr[11:10]}, rpC,
					{cinstr[4:3], 3'd4}, rpA);
			default: expand = nopInstr;
		endcase
	end

endmodule

`default_nettype wire

// File: src/parcelAligner.sv
/*
 * Parcel aligner: collects 16-bit parcels into
 * 16-, 32- and 48-bit instructions
 */
`timescale 1ns/1ps
`include "ft64_macros.svh"
`default_nettype none

module parcelAligner (
	input logic clk,
	input logic reset,
	input logic [`PARCEL_WIDTH-1:0] parcel,
	input logic parcelValid,
	output ft64Pkg::alignedInstrT alignedInstr,
	output logic alignedValid
);
	import ft64Pkg::*;

	alignStateE state;
	logic isLong; // Three-parcel instruction in progress
	logic [2*`PARCEL_WIDTH-1:0] parcelBuf;

	// ====================
	// Control
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			isLong <= 1'b0;
			alignedValid <= 1'b0;
		end
		else
		begin
			alignedValid <= 1'b0;
			if (parcelValid)
			begin
				case (state)
					IDLE:
						if (parcel[7])
							alignedValid <= 1'b1; // Compressed, done
						else
						begin
							isLong <= parcel[6];
							state <= NEED2;
						end
					NEED2:
						if (isLong)
							state <= NEED3;
						else
						begin
							alignedValid <= 1'b1;
							state <= IDLE;
						end
					default:
					begin
						alignedValid <= 1'b1;
						state <= IDLE;
					end
				endcase
			end
		end
	end

	// ====================
	// Payload
	// ====================
	always_ff @(posedge clk)
	begin
		if (parcelValid)
		begin
			case (state)
				IDLE:
				begin
					parcelBuf[`PARCEL_WIDTH-1:0] <= parcel;
					alignedInstr.bits <= `INSTR_WIDTH'(parcel);
					alignedInstr.isCompressed <= parcel[7];
				end
				NEED2:
				begin
					parcelBuf[2*`PARCEL_WIDTH-1:`PARCEL_WIDTH] <= parcel;
					alignedInstr.bits <= `INSTR_WIDTH'({parcel, parcelBuf[`PARCEL_WIDTH-1:0]});
					alignedInstr.isCompressed <= 1'b0;
				end
				default:
				begin
					alignedInstr.bits <= {parcel, parcelBuf};
					alignedInstr.isCompressed <= 1'b0;
				end
			endcase
		end
	end

	// Every emitted instruction leaves the FSM ready for a new first parcel
	assert property (@(posedge clk) disable iff (reset) alignedValid |-> state == IDLE)
		else $error("aligner emitted with a partial instruction pending");

endmodule

`default_nettype wire

// File: src/expandStage.sv
/*
 * Expansion stage: chooses expanded, NOP or native
 * instruction, registers it and pulses the events
 */
`timescale 1ns/1ps
`include "ft64_macros.svh"
`default_nettype none

module expandStage (
	input logic clk,
	input logic reset,
	input ft64Pkg::alignedInstrT alignedInstr,
	input logic alignedValid,
	input logic compressedEnable,
	output logic [`INSTR_WIDTH-1:0] instrOut,
	output logic instrValid,
	output ft64Pkg::expandEventsT events
);
	import ft64Pkg::*;

	logic [`INSTR_WIDTH-1:0] expanded;
	logic [`INSTR_WIDTH-1:0] selected;
	logic compressedIn;

	compressedExpander u_expander (
		.cinstr(alignedInstr.bits[`PARCEL_WIDTH-1:0]),
		.expand(expanded)
	);

	assign compressedIn = alignedValid && alignedInstr.isCompressed;

	always_comb
	begin
		if (!alignedInstr.isCompressed)
			selected = alignedInstr.bits; // Native, already zero-extended
		else if (compressedEnable)
			selected = expanded;
		else
			selected = nopInstr;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instrValid <= 1'b0;
			events <= '0;
		end
		else
		begin
			instrValid <= alignedValid;
			events.issued <= alignedValid;
			events.expanded <= compressedIn && compressedEnable;
			events.illegal <= compressedIn && !compressedEnable;
		end
	end

	always_ff @(posedge clk)
	begin
		if (alignedValid)
			instrOut <= selected;
	end

	assert property (@(posedge clk) disable iff (reset) !(events.expanded && events.illegal))
		else $error("expanded and illegal pulsed together");

endmodule

`default_nettype wire

// File: src/expandControlRegs.sv
/*
 * Control and status registers: compressed enable
 * and event counters behind a small register port
 */
`timescale 1ns/1ps
`include "ft64_macros.svh"
`default_nettype none

module expandControlRegs (
	input logic clk,
	input logic reset,
	input logic regWrite,
	input logic [1:0] regAddr,
	input logic [`REG_DATA_WIDTH-1:0] regWriteData,
	output logic [`REG_DATA_WIDTH-1:0] regReadData,
	input ft64Pkg::expandEventsT events,
	output logic compressedEnable
);
	import ft64Pkg::*;

	localparam int numCounters = 3;

	// Index i sits at address REG_ADDR_EXPANDED + i
	logic [`REG_DATA_WIDTH-1:0] eventCount [numCounters];
	logic [numCounters-1:0] eventPulse;

	assign eventPulse = {events.issued, events.illegal, events.expanded};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			compressedEnable <= 1'b1;
			for (int i = 0; i < numCounters; i++)
				eventCount[i] <= '0;
		end
		else
		begin
			if (regWrite && regAddr == `REG_ADDR_CTRL)
				compressedEnable <= regWriteData[0];
			for (int i = 0; i < numCounters; i++)
			begin
				if (regWrite && regAddr == `REG_ADDR_EXPANDED + 2'(i))
					eventCount[i] <= '0; // Write clears, wins over an event
				else if (eventPulse[i])
					eventCount[i] <= eventCount[i] + 1'b1;
			end
		end
	end

	always_comb
	begin
		case (regAddr)
			`REG_ADDR_CTRL: regReadData = `REG_DATA_WIDTH'(compressedEnable);
			`REG_ADDR_EXPANDED: regReadData = eventCount[0];
			`REG_ADDR_ILLEGAL: regReadData = eventCount[1];
			default: regReadData = eventCount[2]; // REG_ADDR_TOTAL
		endcase
	end

endmodule

`default_nettype wire

// File: src/instrFetchExpand.sv
/*
 * Top level of the fetch-side expansion path: aligner,
 * expansion stage and control registers
 */
`timescale 1ns/1ps
`include "ft64_macros.svh"
`default_nettype none

module instrFetchExpand (
	input logic clk,
	input logic reset,
	input logic [`PARCEL_WIDTH-1:0] parcel,
	input logic parcelValid,
	output logic [`INSTR_WIDTH-1:0] instrOut,
	output logic instrValid,
	input logic regWrite,
	input logic [1:0] regAddr,
	input logic [`REG_DATA_WIDTH-1:0] regWriteData,
	output logic [`REG_DATA_WIDTH-1:0] regReadData
);
	import ft64Pkg::*;

	alignedInstrT alignedInstr;
	logic alignedValid;
	logic compressedEnable;
	expandEventsT events;

	parcelAligner u_aligner (
		.clk(clk),
		.reset(reset),
		.parcel(parcel),
		.parcelValid(parcelValid),
		.alignedInstr(alignedInstr),
		.alignedValid(alignedValid)
	);

	expandStage u_expandStage (
		.clk(clk),
		.reset(reset),
		.alignedInstr(alignedInstr),
		.alignedValid(alignedValid),
		.compressedEnable(compressedEnable),
		.instrOut(instrOut),
		.instrValid(instrValid),
		.events(events)
	);

	expandControlRegs u_controlRegs (
		.clk(clk),
		.reset(reset),
		.regWrite(regWrite),
		.regAddr(regAddr),
		.regWriteData(regWriteData),
		.regReadData(regReadData),
		.events(events),
		.compressedEnable(compressedEnable)
	);

endmodule

`default_nettype wire

// File: testbench/expandVectors.svh
/*
 * Stimulus table entry type and the parcel table
 * Columns are parcel 0, parcel 1, parcel 2, parcel count, expected 48-bit instruction
 */
`ifndef EXPAND_VECTORS_SVH
`define EXPAND_VECTORS_SVH

typedef struct packed
{
	logic [15:0] p0; // First parcel, lowest bits
	logic [15:0] p1;
	logic [15:0] p2;
	logic [1:0] count;
	logic [47:0] expected;
} vectorT;

localparam int numVectors = 28;

localparam vectorT vectorTable [numVectors] = '{
	{16'h01A5, 16'h0000, 16'h0000, 2'd1, 48'h0000_000C_A584}, // ADDI
	{16'h0F9F, 16'h0000, 16'h0000, 2'd1, 48'h0000_FFC3_FF84}, // ADDI on SP, scaled
	{16'h1287, 16'h0000, 16'h0000, 2'd1, 48'h0000_0010_E085}, // LDI
	{16'h10A0, 16'h0000, 16'h0000, 2'd1, 48'h0000_0020_2183}, // BRK
	{16'h2180, 16'h0000, 16'h0000, 2'd1, 48'h0000_0177_FF87}, // RET
	{16'h28A3, 16'h0000, 16'h0000, 2'd1, 48'h0000_FFC4_6386}, // ANDI negative
	{16'h32AA, 16'h0000, 16'h0000, 2'd1, 48'h0000_3C15_4A82}, // SHLI
	{16'h418A, 16'h0000, 16'h0000, 2'd1, 48'h0000_3C8C_8482}, // SHRI
	{16'h4497, 16'h0000, 16'h0000, 2'd1, 48'h0000_3DA2_9482}, // ASRI
	{16'h40A8, 16'h0000, 16'h0000, 2'd1, 48'h0000_0004_2185}, // ORI mapped
	{16'h41BD, 16'h0000, 16'h0000, 2'd1, 48'h0000_15AE_5282}, // SUB pair
	{16'h4EB6, 16'h0000, 16'h0000, 2'd1, 48'h0000_29B2_7382}, // XOR pair
	{16'h7396, 16'h0000, 16'h0000, 2'd1, 48'h0000_1A82_00B8}, // Branch always
	{16'h8D84, 16'h0000, 16'h0000, 2'd1, 48'h0000_0302_04B8}, // BEQ
	{16'hFCB2, 16'h0000, 16'h0000, 2'd1, 48'h0000_FF01_32B8}, // BNE backward
	{16'h04E6, 16'h0000, 16'h0000, 2'd1, 48'h0000_4B81_2682}, // MOV
	{16'h1AC2, 16'h0000, 16'h0000, 2'd1, 48'h0000_11D0_4282}, // ADD
	{16'h2EED, 16'h0000, 16'h0000, 2'd1, 48'h0000_0003_AD88}, // JAL
	{16'h30C9, 16'h0000, 16'h0000, 2'd1, 48'h0000_C027_FFBB}, // PUSH
	{16'h31C9, 16'h0000, 16'h0000, 2'd1, 48'h0000_0000_00BC}, // Unlisted, NOP
	{16'h43C8, 16'h0000, 16'h0000, 2'd1, 48'h0000_0069_1FB9}, // LH from SP
	{16'h78E1, 16'h0000, 16'h0000, 2'd1, 48'h0000_FE30_3EB9}, // LW from FP
	{16'h95E5, 16'h0000, 16'h0000, 2'd1, 48'h0000_0117_9FBA}, // SW to SP
	{16'hD6F1, 16'h0000, 16'h0000, 2'd1, 48'h0000_00D2_43B9}, // LW mapped
	{16'hE9DC, 16'h0000, 16'h0000, 2'd1, 48'h0000_FF91_CCBA}, // SH mapped
	{16'h1234, 16'hABCD, 16'h0000, 2'd2, 48'h0000_ABCD_1234}, // Native 32-bit
	{16'h5A47, 16'h9876, 16'hFEDC, 2'd3, 48'hFEDC_9876_5A47}, // Native 48-bit
	{16'hC001, 16'h0000, 16'h0000, 2'd2, 48'h0000_0000_C001}
};

`endif

// File: testbench/tbInstrFetchExpand.sv
/*
 * Testbench for the fetch-side expansion path: table-driven parcel stimulus,
 * output and latency checks, event counter checks, watchdog
 */
`timescale 1ns/1ps
`include "ft64_macros.svh"
`default_nettype none

module tbInstrFetchExpand;

	`include "expandVectors.svh"

	localparam logic [`INSTR_WIDTH-1:0] nopForm = 48'h0000_0000_00BC; // NOP opcode, fields zero
	localparam int watchdogCycles = numVectors * 10 + 200;

	logic clk;
	logic reset;
	logic [`PARCEL_WIDTH-1:0] parcel;
	logic parcelValid;
	logic [`INSTR_WIDTH-1:0] instrOut;
	logic instrValid;
	logic regWrite;
	logic [1:0] regAddr;
	logic [`REG_DATA_WIDTH-1:0] regWriteData;
	logic [`REG_DATA_WIDTH-1:0] regReadData;

	integer seed;
	int cycleCount; // Rising edges seen so far
	logic compressedOn; // Enable bit as last written
	int expandedTally;
	int illegalTally;
	int issuedTally;
	logic [`INSTR_WIDTH-1:0] pendingInstr [$];
	int pendingCycle [$]; // Cycle in which each output must appear
	logic [`REG_DATA_WIDTH-1:0] readData;

	instrFetchExpand u_dut (
		.clk(clk),
		.reset(reset),
		.parcel(parcel),
		.parcelValid(parcelValid),
		.instrOut(instrOut),
		.instrValid(instrValid),
		.regWrite(regWrite),
		.regAddr(regAddr),
		.regWriteData(regWriteData),
		.regReadData(regReadData)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================
	task automatic checkValue(
		input logic [`INSTR_WIDTH-1:0] actual,
		input logic [`INSTR_WIDTH-1:0] expected,
		input string what
	);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic readReg(input logic [1:0] addr, output logic [`REG_DATA_WIDTH-1:0] data);
		@(negedge clk);
		regAddr = addr;
		#1;
		data = regReadData; // Settled well before the next rising edge
	endtask

	task automatic writeReg(input logic [1:0] addr, input logic [`REG_DATA_WIDTH-1:0] data);
		@(negedge clk);
		regWrite = 1'b1;
		regAddr = addr;
		regWriteData = data;
		@(negedge clk);
		regWrite = 1'b0;
		regWriteData = '0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			parcelValid = 1'b0;
			parcel = '0;
		end
	endtask

	task automatic sendInstruction(input vectorT v);
		logic [`PARCEL_WIDTH-1:0] parcels [3];
		logic [`INSTR_WIDTH-1:0] expected;
		parcels[0] = v.p0;
		parcels[1] = v.p1;
		parcels[2] = v.p2;
		for (int i = 0; i < int'(v.count); i++)
		begin
			@(negedge clk);
			parcel = parcels[i];
			parcelValid = 1'b1;
		end
		expected = v.expected;
		if (v.count == 2'd1)
		begin
			if (compressedOn)
				expandedTally++;
			else
			begin
				expected = nopForm; // Disabled decode
				illegalTally++;
			end
		end
		issuedTally++;
		pendingInstr.push_back(expected);
		pendingCycle.push_back(cycleCount + 2); // Two cycles after the last strobe
	endtask

	task automatic runTable(input logic randomGaps);
		int gap;
		for (int n = 0; n < numVectors; n++)
		begin
			sendInstruction(vectorTable[n]);
			gap = 0;
			if (randomGaps)
				gap = int'($unsigned($random(seed)) % 4);
			idleCycles(gap);
		end
		idleCycles(1);
	endtask

	task automatic waitDrain();
		while (pendingInstr.size() != 0)
			@(negedge clk);
	endtask

	task automatic checkCounters();
		logic [`REG_DATA_WIDTH-1:0] data;
		readReg(`REG_ADDR_EXPANDED, data);
		checkValue(48'(data), 48'(expandedTally), "expanded counter");
		readReg(`REG_ADDR_ILLEGAL, data);
		checkValue(48'(data), 48'(illegalTally), "illegal counter");
		readReg(`REG_ADDR_TOTAL, data);
		checkValue(48'(data), 48'(issuedTally), "issued counter");
	endtask

	// ====================
	// Output monitor
	// ====================
	initial
	begin
		cycleCount = 0;
		forever
		begin
			@(posedge clk);
			if (!reset && instrValid)
			begin
				if (pendingInstr.size() == 0)
				begin
					$display("Unexpected output %h at %0t ns with no instruction pending",
						instrOut, $time);
					$display("SIMULATION FAILED");
					$fatal(1, "unexpected instruction");
				end
				else
				begin
					checkValue(instrOut, pendingInstr.pop_front(), "instruction");
					checkValue(48'(cycleCount), 48'(pendingCycle.pop_front()), "arrival cycle");
				end
			end
			cycleCount++;
		end
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	// ====================
	// Main sequence
	// ====================
	initial
	begin
		reset = 1'b1;
		parcel = '0;
		parcelValid = 1'b0;
		regWrite = 1'b0;
		regAddr = '0;
		regWriteData = '0;
		seed = 2892;
		compressedOn = 1'b1;
		expandedTally = 0;
		illegalTally = 0;
		issuedTally = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		readReg(`REG_ADDR_CTRL, readData);
		checkValue(48'(readData), 48'd1, "enable after reset");
		checkCounters();

		runTable(1'b1); // Random gaps between instructions
		waitDrain();
		checkCounters();

		runTable(1'b0); // Back to back
		waitDrain();
		checkCounters();

		writeReg(`REG_ADDR_CTRL, 32'd0);
		compressedOn = 1'b0;
		readReg(`REG_ADDR_CTRL, readData);
		checkValue(48'(readData), 48'd0, "enable after write");
		runTable(1'b1);
		waitDrain();
		checkCounters();

		// Any write clears a counter
		for (int a = 1; a <= 3; a++)
		begin
			writeReg(2'(a), 32'hFFFF_FFFF);
			readReg(2'(a), readData);
			checkValue(48'(readData), 48'd0, "counter after clear");
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
+incdir+testbench
src/ft64Pkg.sv
src/compressedExpander.sv
src/parcelAligner.sv
src/expandStage.sv
src/expandControlRegs.sv
src/instrFetchExpand.sv
testbench/tbInstrFetchExpand.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the expansion path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module tbInstrFetchExpand -o simExpand
./obj_dir/simExpand | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
	echo "Test run passed"
else
	echo "Test run failed"
	exit 1
fi
